// ==== hw/sfm_defines.svh ====
`ifndef SFM_DEFINES_SVH
`define SFM_DEFINES_SVH

`define SFM_DATA_WIDTH 64 // Memory word
`define SFM_LANES 4
`define SFM_LANE_WIDTH 16 // One Q8.8 element
`define SFM_ADDR_WIDTH 16 // Word address
`define SFM_LEN_WIDTH 12 // Element count

`endif

// ==== hw/sfm_pkg.sv ====
`include "sfm_defines.svh"

package sfm_pkg;

    // Signed Q8.8 input element
    typedef logic signed [`SFM_LANE_WIDTH-1:0] lane_t;

    // Unsigned Q1.15, so 32768 stands for 1.0
    typedef logic [`SFM_LANE_WIDTH-1:0] exp_t;

    typedef logic [31:0] sum_t; // Room for 1024 words of four 1.0 lanes

    typedef enum logic [1:0] {
        DP_IDLE,
        DP_MAX,
        DP_EXP
    } dp_op_e;

endpackage

// ==== hw/sfm_stream_pkg.sv ====
`include "sfm_defines.svh"

package sfm_stream_pkg;

    typedef logic [`SFM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`SFM_LEN_WIDTH-1:0] len_t;
    typedef logic [`SFM_LANES-1:0] strb_t;

    typedef enum logic {
        PASS_READ_ONLY, // Feeds the datapath only
        PASS_READ_WRITE // Also writes the datapath results back
    } pass_e;

endpackage

// ==== hw/sfm_ctrl.sv ====
`timescale 1ns/1ps

module sfm_ctrl
    import sfm_pkg::*;
    import sfm_stream_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   start_i,
    input  addr_t  src_addr_i,
    input  addr_t  dst_addr_i,
    input  len_t   length_i,
    input  logic   strm_done_i,
    input  logic   dp_empty_i,
    output logic   strm_start_o,
    output pass_e  strm_pass_o,
    output addr_t  strm_src_o,
    output addr_t  strm_dst_o,
    output len_t   strm_len_o,
    output dp_op_e dp_op_o,
    output logic   dp_first_o,
    output logic   busy_o,
    output logic   done_o
);

    typedef enum logic [1:0] {
        IDLE,
        MAX_PASS,
        EXP_PASS,
        FINISH
    } state_e;

    state_e state_q;
    logic   launch_q;
    logic   strm_seen_q;
    addr_t  src_q;
    addr_t  dst_q;
    len_t   len_q;
    logic   pass_end;

    // A pass is over once the streamer is finished and nothing is left in the pipeline
    assign pass_end = (strm_seen_q || strm_done_i) && dp_empty_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            launch_q    <= 1'b0;
            strm_seen_q <= 1'b0;
        end else begin
            launch_q <= 1'b0;
            if (strm_done_i) begin
                strm_seen_q <= 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q     <= MAX_PASS;
                        launch_q    <= 1'b1;
                        strm_seen_q <= 1'b0;
                    end
                end
                MAX_PASS: begin
                    if (pass_end) begin
                        state_q     <= EXP_PASS;
                        launch_q    <= 1'b1;
                        strm_seen_q <= 1'b0;
                    end
                end
                EXP_PASS: begin
                    if (pass_end) begin
                        state_q     <= FINISH;
                        strm_seen_q <= 1'b0;
                    end
                end
                default: state_q <= IDLE; // FINISH lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            src_q <= src_addr_i;
            dst_q <= dst_addr_i;
            len_q <= length_i;
        end
    end

    assign strm_start_o = launch_q; // One cycle after each pass state is entered
    assign dp_first_o   = launch_q;
    assign strm_pass_o  = (state_q == EXP_PASS) ? PASS_READ_WRITE : PASS_READ_ONLY;
    assign strm_src_o   = src_q;
    assign strm_dst_o   = dst_q;
    assign strm_len_o   = len_q;

    always_comb begin
        case (state_q)
            MAX_PASS: dp_op_o = DP_MAX;
            EXP_PASS: dp_op_o = DP_EXP;
            default:  dp_op_o = DP_IDLE;
        endcase
    end

    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == FINISH);

endmodule

// ==== hw/sfm_streamer.sv ====
`timescale 1ns/1ps
`include "sfm_defines.svh"

module sfm_streamer
    import sfm_stream_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       start_i,
    input  pass_e                      pass_i,
    input  addr_t                      src_i,
    input  addr_t                      dst_i,
    input  len_t                       len_i,
    output logic                       done_o,
    output logic                       in_valid_o,
    output logic [`SFM_DATA_WIDTH-1:0] in_data_o,
    output strb_t                      in_strb_o,
    input  logic                       in_ready_i,
    input  logic                       out_valid_i,
    input  logic [`SFM_DATA_WIDTH-1:0] out_data_i,
    input  strb_t                      out_strb_i,
    output logic                       out_ready_o,
    output logic                       mem_req_o,
    output logic                       mem_we_o,
    output addr_t                      mem_addr_o,
    output strb_t                      mem_be_o,
    output logic [`SFM_DATA_WIDTH-1:0] mem_wdata_o,
    input  logic                       mem_gnt_i,
    input  logic                       mem_rvalid_i,
    input  logic [`SFM_DATA_WIDTH-1:0] mem_rdata_i
);

    logic                       active_q;
    pass_e                      pass_q;
    addr_t                      src_q;
    addr_t                      dst_q;
    len_t                       words_q;
    strb_t                      tail_q;
    len_t                       rd_cnt_q; // Reads granted
    len_t                       dl_cnt_q; // Words handed to the datapath
    len_t                       wr_cnt_q; // Writes granted
    logic                       rd_outst_q;
    logic                       rd_lock_q;
    logic                       wr_pend_q;
    logic [`SFM_DATA_WIDTH-1:0] wr_data_q;
    strb_t                      wr_strb_q;
    logic [`SFM_DATA_WIDTH-1:0] fifo_q [2];
    logic                       fifo_wr_q;
    logic                       fifo_rd_q;
    logic [1:0]                 fifo_cnt_q;
    logic [`SFM_LEN_WIDTH:0]    len_ext;
    logic                       rd_avail;
    logic                       sel_wr;
    logic                       sel_rd;
    logic                       pop;
    logic                       last_dl;
    logic                       last_wr;

    assign len_ext = {1'b0, len_i} + 3; // Round up to whole words

    // A read goes out only while the return buffer can still take its data
    assign rd_avail = active_q && (rd_cnt_q != words_q)
                      && (fifo_cnt_q + {1'b0, rd_outst_q} < 2'd2);

    // A waiting write wins unless a read is already on the port
    assign sel_wr = wr_pend_q && !rd_lock_q;
    assign sel_rd = !sel_wr && rd_avail;

    assign mem_req_o   = sel_wr || sel_rd;
    assign mem_we_o    = sel_wr;
    assign mem_addr_o  = sel_wr ? dst_q + addr_t'(wr_cnt_q) : src_q + addr_t'(rd_cnt_q);
    assign mem_be_o    = sel_wr ? wr_strb_q : '1;
    assign mem_wdata_o = wr_data_q;

    assign in_valid_o  = (fifo_cnt_q != 2'd0);
    assign in_data_o   = fifo_q[fifo_rd_q];
    assign in_strb_o   = (dl_cnt_q == words_q - 1) ? tail_q : '1;
    assign out_ready_o = !wr_pend_q;

    assign pop     = in_valid_o && in_ready_i;
    assign last_dl = pop && (dl_cnt_q == words_q - 1);
    assign last_wr = sel_wr && mem_gnt_i && (wr_cnt_q == words_q - 1);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q   <= 1'b0;
            done_o     <= 1'b0;
            rd_cnt_q   <= '0;
            dl_cnt_q   <= '0;
            wr_cnt_q   <= '0;
            rd_outst_q <= 1'b0;
            rd_lock_q  <= 1'b0;
            wr_pend_q  <= 1'b0;
            fifo_wr_q  <= 1'b0;
            fifo_rd_q  <= 1'b0;
            fifo_cnt_q <= '0;
        end else begin
            rd_outst_q <= sel_rd && mem_gnt_i; // Data comes back on the next cycle
            rd_lock_q  <= sel_rd && !mem_gnt_i;
            // The read-only pass ends when its last word has reached the datapath
            done_o     <= active_q && ((pass_q == PASS_READ_ONLY) ? last_dl : last_wr);
            if (start_i) begin
                active_q   <= 1'b1;
                rd_cnt_q   <= '0;
                dl_cnt_q   <= '0;
                wr_cnt_q   <= '0;
                fifo_wr_q  <= 1'b0;
                fifo_rd_q  <= 1'b0;
                fifo_cnt_q <= '0;
            end else begin
                if (done_o) begin
                    active_q <= 1'b0;
                end
                if (sel_rd && mem_gnt_i) begin
                    rd_cnt_q <= rd_cnt_q + 1;
                end
                if (sel_wr && mem_gnt_i) begin
                    wr_cnt_q <= wr_cnt_q + 1;
                end
                if (pop) begin
                    dl_cnt_q  <= dl_cnt_q + 1;
                    fifo_rd_q <= !fifo_rd_q;
                end
                if (mem_rvalid_i) begin
                    fifo_wr_q <= !fifo_wr_q;
                end
                fifo_cnt_q <= fifo_cnt_q + {1'b0, mem_rvalid_i} - {1'b0, pop};
            end
            if (out_valid_i && out_ready_o) begin
                wr_pend_q <= 1'b1;
            end else if (sel_wr && mem_gnt_i) begin
                wr_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            pass_q  <= pass_i;
            src_q   <= src_i;
            dst_q   <= dst_i;
            words_q <= len_t'(len_ext[`SFM_LEN_WIDTH:2]);
            tail_q  <= (len_i[1:0] == 2'd0) ? '1 : (strb_t'(1) << len_i[1:0]) - strb_t'(1);
        end
        if (mem_rvalid_i) begin
            fifo_q[fifo_wr_q] <= mem_rdata_i;
        end
        if (out_valid_i && out_ready_o) begin
            wr_data_q <= out_data_i;
            wr_strb_q <= out_strb_i;
        end
    end

endmodule

// ==== hw/sfm_datapath.sv ====
`timescale 1ns/1ps
`include "sfm_defines.svh"

module sfm_datapath
    import sfm_pkg::*;
    import sfm_stream_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  dp_op_e                     op_i,
    input  logic                       first_i,
    input  logic                       valid_i,
    input  logic [`SFM_DATA_WIDTH-1:0] data_i,
    input  strb_t                      strb_i,
    output logic                       ready_o,
    output logic                       valid_o,
    output logic [`SFM_DATA_WIDTH-1:0] res_o,
    output strb_t                      strb_o,
    input  logic                       ready_i,
    output logic                       empty_o,
    output lane_t                      max_o,
    output sum_t                       sum_o
);

    localparam int W = `SFM_LANE_WIDTH;
    localparam lane_t LANE_MIN = {1'b1, {(W-1){1'b0}}};
    localparam exp_t EXP_ONE = {1'b1, {(W-1){1'b0}}}; // 1.0 in Q1.15

    lane_t                      max_q;
    lane_t                      max_d;
    sum_t                       sum_q;
    sum_t                       exp_sum;
    logic                       s1_valid_q;
    logic [7:0]                 s1_int_q [`SFM_LANES]; // q, whole steps below the max
    logic [7:0]                 s1_frac_q [`SFM_LANES]; // r, fraction of a step
    logic [7:0]                 int_d [`SFM_LANES];
    logic [7:0]                 frac_d [`SFM_LANES];
    strb_t                      s1_strb_q;
    logic                       s2_valid_q;
    logic [`SFM_DATA_WIDTH-1:0] s2_res_q;
    logic [`SFM_DATA_WIDTH-1:0] res_d;
    strb_t                      s2_strb_q;
    logic                       s2_adv;
    logic                       s1_free;
    logic                       in_fire;

    assign s2_adv  = !s2_valid_q || ready_i;
    assign s1_free = !s1_valid_q || s2_adv;
    // The max pass keeps no item in the pipeline, so it never stalls
    assign ready_o = (op_i == DP_MAX) || (op_i == DP_EXP && s1_free);
    assign in_fire = valid_i && ready_o;

    always_comb begin
        lane_t          x;
        logic [W:0]     diff;
        max_d = (first_i && op_i == DP_MAX) ? LANE_MIN : max_q;
        for (int i = 0; i < `SFM_LANES; i++) begin
            x    = lane_t'(data_i[i*W +: W]);
            diff = {max_q[W-1], max_q} - {x[W-1], x}; // Never negative within a vector
            int_d[i]  = diff[15:8];
            frac_d[i] = diff[7:0];
            if (in_fire && strb_i[i] && x > max_d) begin
                max_d = x;
            end
        end
    end

    // 2^-(q + r/256) is taken as (1 - r/512) >> q
    always_comb begin
        exp_t e;
        exp_sum = '0;
        res_d   = '0;
        for (int i = 0; i < `SFM_LANES; i++) begin
            if (!s1_strb_q[i] || s1_int_q[i] >= 8'd16) begin
                e = '0;
            end else begin
                e = (EXP_ONE - exp_t'({s1_frac_q[i], 6'b0})) >> s1_int_q[i];
            end
            res_d[i*W +: W] = e;
            exp_sum         = exp_sum + sum_t'(e);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            max_q      <= LANE_MIN;
            sum_q      <= '0;
        end else begin
            if (s1_free) begin
                s1_valid_q <= in_fire && (op_i == DP_EXP);
            end
            if (s2_adv) begin
                s2_valid_q <= s1_valid_q;
            end
            if (op_i == DP_MAX) begin
                max_q <= max_d;
            end
            if (first_i && op_i == DP_EXP) begin
                sum_q <= '0;
            end else if (s1_valid_q && s2_adv) begin
                sum_q <= sum_q + exp_sum;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_free && in_fire) begin
            s1_int_q  <= int_d;
            s1_frac_q <= frac_d;
            s1_strb_q <= strb_i;
        end
        if (s2_adv && s1_valid_q) begin
            s2_res_q  <= res_d;
            s2_strb_q <= s1_strb_q;
        end
    end

    assign valid_o = s2_valid_q;
    assign res_o   = s2_res_q;
    assign strb_o  = s2_strb_q;
    assign empty_o = !s1_valid_q && !s2_valid_q;
    assign max_o   = max_q;
    assign sum_o   = sum_q;

endmodule

// ==== hw/sfm_top.sv ====
`timescale 1ns/1ps
`include "sfm_defines.svh"

module sfm_top
    import sfm_pkg::*;
    import sfm_stream_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       start_i,
    input  addr_t                      src_addr_i,
    input  addr_t                      dst_addr_i,
    input  len_t                       length_i,
    output logic                       busy_o,
    output logic                       done_o,
    output lane_t                      max_o,
    output sum_t                       sum_o,
    output logic                       mem_req_o,
    output logic                       mem_we_o,
    output addr_t                      mem_addr_o,
    output strb_t                      mem_be_o,
    output logic [`SFM_DATA_WIDTH-1:0] mem_wdata_o,
    input  logic                       mem_gnt_i,
    input  logic                       mem_rvalid_i,
    input  logic [`SFM_DATA_WIDTH-1:0] mem_rdata_i
);

    logic                       strm_start;
    pass_e                      strm_pass;
    addr_t                      strm_src;
    addr_t                      strm_dst;
    len_t                       strm_len;
    logic                       strm_done;
    dp_op_e                     dp_op;
    logic                       dp_first;
    logic                       dp_empty;
    logic                       in_valid;
    logic [`SFM_DATA_WIDTH-1:0] in_data;
    strb_t                      in_strb;
    logic                       in_ready;
    logic                       out_valid;
    logic [`SFM_DATA_WIDTH-1:0] out_data;
    strb_t                      out_strb;
    logic                       out_ready;

    sfm_ctrl i_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (start_i),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .length_i     (length_i),
        .strm_done_i  (strm_done),
        .dp_empty_i   (dp_empty),
        .strm_start_o (strm_start),
        .strm_pass_o  (strm_pass),
        .strm_src_o   (strm_src),
        .strm_dst_o   (strm_dst),
        .strm_len_o   (strm_len),
        .dp_op_o      (dp_op),
        .dp_first_o   (dp_first),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    sfm_streamer i_streamer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (strm_start),
        .pass_i       (strm_pass),
        .src_i        (strm_src),
        .dst_i        (strm_dst),
        .len_i        (strm_len),
        .done_o       (strm_done),
        .in_valid_o   (in_valid),
        .in_data_o    (in_data),
        .in_strb_o    (in_strb),
        .in_ready_i   (in_ready),
        .out_valid_i  (out_valid),
        .out_data_i   (out_data),
        .out_strb_i   (out_strb),
        .out_ready_o  (out_ready),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_be_o     (mem_be_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    sfm_datapath i_datapath (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .op_i    (dp_op),
        .first_i (dp_first),
        .valid_i (in_valid),
        .data_i  (in_data),
        .strb_i  (in_strb),
        .ready_o (in_ready),
        .valid_o (out_valid),
        .res_o   (out_data),
        .strb_o  (out_strb),
        .ready_i (out_ready),
        .empty_o (dp_empty),
        .max_o   (max_o),
        .sum_o   (sum_o)
    );

endmodule

// ==== test/sfm_checker.sv ====
`timescale 1ns/1ps
`include "sfm_defines.svh"

module sfm_checker
    import sfm_pkg::*;
    import sfm_stream_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       busy_i,
    input  logic                       done_i,
    input  lane_t                      max_i,
    input  sum_t                       sum_i,
    input  logic                       mem_req_i,
    input  logic                       mem_we_i,
    input  addr_t                      mem_addr_i,
    input  strb_t                      mem_be_i,
    input  logic [`SFM_DATA_WIDTH-1:0] mem_wdata_i,
    input  logic                       mem_gnt_i,
    output int                         errors_o,
    output int                         tests_o,
    output int                         failed_o
);

    logic [31:0] td [0:255];
    int          test_idx = 0;
    int          base = 1; // Start of the current test in the data file
    int          wr_cnt = 0;
    int          test_err = 0;
    int          err_cnt = 0;
    int          fail_cnt = 0;
    logic        reset_checked = 1'b0;

    assign errors_o = err_cnt;
    assign tests_o  = test_idx;
    assign failed_o = fail_cnt;

    initial begin
        $readmemh("test/sfm_input.txt", td);
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp_v, got_v);
        test_err++;
        err_cnt++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        test_err++;
        err_cnt++;
    endtask

    // Lanes of word w that lie inside a vector of len elements
    function automatic strb_t lane_mask(input int len, input int w);
        strb_t m;
        for (int l = 0; l < `SFM_LANES; l++) begin
            m[l] = (w * `SFM_LANES + l) < len;
        end
        return m;
    endfunction

    always @(posedge clk_i) begin
        int          len;
        logic [15:0] idx;
        strb_t       be_exp;
        logic [15:0] lane_exp;
        if (rst_n_i) begin
            if (!reset_checked) begin
                if (busy_i || done_i || mem_req_i) begin
                    report_failure("busy_o, done_o or mem_req_o is high after reset");
                end
                reset_checked = 1'b1;
            end
            len = td[base];
            if (mem_req_i && mem_we_i && mem_gnt_i) begin
                idx = mem_addr_i - td[base+2][15:0];
                if (int'(idx) != wr_cnt) begin
                    report_mismatch("mem_addr_o", td[base+2] + wr_cnt, {16'b0, mem_addr_i});
                end else if (wr_cnt >= (len + 3) / 4) begin
                    report_failure("a write went past the end of the destination vector");
                end else begin
                    be_exp = lane_mask(len, wr_cnt);
                    if (mem_be_i != be_exp) begin
                        report_mismatch("mem_be_o", {28'b0, be_exp}, {28'b0, mem_be_i});
                    end
                    for (int l = 0; l < `SFM_LANES; l++) begin
                        lane_exp = td[base + 5 + len + wr_cnt * 4 + l][15:0];
                        if (be_exp[l] && mem_wdata_i[l*16 +: 16] != lane_exp) begin
                            report_mismatch($sformatf("mem_wdata_o lane %0d", l),
                                            {16'b0, lane_exp}, {16'b0, mem_wdata_i[l*16 +: 16]});
                        end
                    end
                end
                wr_cnt++;
            end
            if (done_i) begin
                if (test_idx >= int'(td[0])) begin
                    report_failure("done_o pulsed with no test running");
                end else begin
                    if (max_i != td[base+3][15:0]) begin
                        report_mismatch("max_o", {16'b0, td[base+3][15:0]}, {16'b0, max_i});
                    end
                    if (sum_i != td[base+4]) begin
                        report_mismatch("sum_o", td[base+4], sum_i);
                    end
                    if (wr_cnt != (len + 3) / 4) begin
                        report_failure("the number of written words is wrong");
                    end
                    $display("test %0d length %0d: %s", test_idx, len,
                             (test_err == 0) ? "ok" : "failed");
                    if (test_err != 0) begin
                        fail_cnt++;
                    end
                    test_idx++;
                    base     = base + 5 + 2 * len;
                    wr_cnt   = 0;
                    test_err = 0;
                end
            end
        end
    end

endmodule

// ==== test/tb_sfm.sv ====
`timescale 1ns/1ps
`include "sfm_defines.svh"

module tb_sfm
    import sfm_pkg::*;
    import sfm_stream_pkg::*;
();

    logic                       clk_i = 1'b0;
    logic                       rst_n_i = 1'b0;
    logic                       start_i = 1'b0;
    addr_t                      src_addr_i = '0;
    addr_t                      dst_addr_i = '0;
    len_t                       length_i = '0;
    logic                       busy_o;
    logic                       done_o;
    lane_t                      max_o;
    sum_t                       sum_o;
    logic                       mem_req_o;
    logic                       mem_we_o;
    addr_t                      mem_addr_o;
    strb_t                      mem_be_o;
    logic [`SFM_DATA_WIDTH-1:0] mem_wdata_o;
    logic                       mem_gnt_i = 1'b0;
    logic                       mem_rvalid_i = 1'b0;
    logic [`SFM_DATA_WIDTH-1:0] mem_rdata_i = '0;

    logic [`SFM_DATA_WIDTH-1:0] mem [0:65535];
    logic [31:0]                td [0:255];
    logic [31:0]                rng = 32'h8cb8e064;
    longint                     limit_cycles = 0;
    int                         err_cnt;
    int                         tests_run;
    int                         fail_cnt;

    always #2 clk_i = ~clk_i;

    sfm_top dut (.*);

    sfm_checker i_checker (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .busy_i      (busy_o),
        .done_i      (done_o),
        .max_i       (max_o),
        .sum_i       (sum_o),
        .mem_req_i   (mem_req_o),
        .mem_we_i    (mem_we_o),
        .mem_addr_i  (mem_addr_o),
        .mem_be_i    (mem_be_o),
        .mem_wdata_i (mem_wdata_o),
        .mem_gnt_i   (mem_gnt_i),
        .errors_o    (err_cnt),
        .tests_o     (tests_run),
        .failed_o    (fail_cnt)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lanes 2 and 3 hold large positive values, so a leaked tail lane would win the max
    function automatic logic [63:0] fill_word(input logic [15:0] a);
        return {16'h7f00 ^ a, a ^ 16'h5555, ~a, a + 16'h4321};
    endfunction

    // Memory with random grants and read data one cycle after the grant
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_gnt_i    <= 1'b0;
            mem_rvalid_i <= 1'b0;
        end else begin
            rng = xorshift(rng);
            mem_gnt_i    <= (rng[1:0] != 2'd0);
            mem_rvalid_i <= mem_req_o && mem_gnt_i && !mem_we_o;
            if (mem_req_o && mem_gnt_i && !mem_we_o) begin
                mem_rdata_i <= mem[mem_addr_o];
            end
            if (mem_req_o && mem_gnt_i && mem_we_o) begin
                for (int l = 0; l < `SFM_LANES; l++) begin
                    if (mem_be_o[l]) begin
                        mem[mem_addr_o][l*16 +: 16] <= mem_wdata_o[l*16 +: 16];
                    end
                end
            end
        end
    end

    task automatic run_test(input int b);
        @(posedge clk_i);
        start_i    <= 1'b1;
        length_i   <= td[b][11:0];
        src_addr_i <= td[b+1][15:0];
        dst_addr_i <= td[b+2][15:0];
        @(posedge clk_i);
        start_i <= 1'b0;
        @(posedge clk_i);
        start_i    <= 1'b1; // Lands while busy_o is high and must be dropped
        length_i   <= 12'd1;
        src_addr_i <= 16'hff00;
        dst_addr_i <= 16'hff80;
        @(posedge clk_i);
        start_i <= 1'b0;
        do @(posedge clk_i); while (!done_o);
    endtask

    initial begin
        int          b;
        int          len;
        int          max_len;
        logic [15:0] src;
        $readmemh("test/sfm_input.txt", td);
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fill_word(a[15:0]);
        end
        b       = 1;
        max_len = 0;
        for (int t = 0; t < int'(td[0]); t++) begin
            len = td[b];
            src = td[b+1][15:0];
            if (len > max_len) begin
                max_len = len;
            end
            for (int i = 0; i < len; i++) begin
                mem[src + 16'(i / 4)][(i % 4) * 16 +: 16] = td[b + 5 + i][15:0];
            end
            b = b + 5 + 2 * len;
        end
        limit_cycles = longint'(td[0]) * (max_len * 40 + 200);
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        b = 1;
        for (int t = 0; t < int'(td[0]); t++) begin
            run_test(b);
            b = b + 5 + 2 * int'(td[b]);
        end
        repeat (5) @(posedge clk_i);
        $display("tests run %0d of %0d, failed %0d, errors %0d", tests_run, td[0], fail_cnt,
                 err_cnt);
        if (err_cnt == 0 && tests_run == int'(td[0])) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * 4);
        $display("Timeout: the engine did not finish all tests in %0d cycles", limit_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== test/sfm_input.txt ====
// First value: number of tests. Per test, line 1: length src dst max sum,
// line 2: elements (Q8.8), line 3: expected exponents (Q1.15)
4
// Full word, max first
4 0010 0100 0100 00014000
0100 0000 0080 ff00
8000 4000 6000 2000
// Tail word of two lanes, one distance above 16
6 0020 0200 0340 0000ad80
0000 f000 0040 ffc0 0340 fe00
0e00 0000 1000 0c00 8000 0380
// Single element
1 0030 0300 ff80 00008000
ff80
8000
// Two full words of negative values
8 0040 0400 ff00 0001f003
ff00 fe80 f100 8000 fd00 ff00 fec0 f080
8000 6000 0002 0000 2000 8000 7000 0001

// ==== flist.f ====
+incdir+hw
hw/sfm_pkg.sv
hw/sfm_stream_pkg.sv
hw/sfm_ctrl.sv
hw/sfm_streamer.sv
hw/sfm_datapath.sv
hw/sfm_top.sv
test/sfm_checker.sv
test/tb_sfm.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the softmax engine testbench with Verilator

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_sfm -Mdir obj_dir -o sim_sfm
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

out=$(./obj_dir/sim_sfm)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
else
    echo "Pass message not found"
    exit 1
fi
